//--- mul_types_pkg.sv
package mul_types_pkg;

    // Operand width used when the top level is not overridden.
    localparam int DEFAULT_WIDTH = 16;

    // How the two operands are read.
    // Unsigned takes the raw bits.
    // Signed reads them as two's complement.
    typedef enum logic {
        MODE_UNSIGNED = 1'b0,
        MODE_SIGNED   = 1'b1
    } op_mode_t;

endpackage

//--- mul_ctrl_pkg.sv
package mul_ctrl_pkg;

    // Controller states.
    // IDLE waits for start, LOAD waits for in_valid.
    // CALC runs the shift-add steps until done.
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        LOAD = 3'd1,
        CALC = 3'd2
    } ctrl_state_t;

endpackage

//--- operand_conditioner.sv
`timescale 1ns/10ps

module operand_conditioner #(
    parameter int WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  mul_types_pkg::op_mode_t mode,
    input  logic [WIDTH-1:0]        a,
    input  logic [WIDTH-1:0]        b,
    output logic [WIDTH-1:0]        mag_a,
    output logic [WIDTH-1:0]        mag_b,
    output logic                    neg
);

    import mul_types_pkg::*;

    logic             signed_mode;
    logic [WIDTH-1:0] abs_a;
    logic [WIDTH-1:0] abs_b;

    assign signed_mode = (mode == MODE_SIGNED);

    // Magnitudes of the operands.
    // The most negative value maps to 2**(WIDTH-1), which still fits unsigned.
    assign abs_a = (signed_mode && a[WIDTH-1]) ? (~a + 1'b1) : a;
    assign abs_b = (signed_mode && b[WIDTH-1]) ? (~b + 1'b1) : b;

    // Capture on load, then hold for the whole calculation.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mag_a <= '0;
            mag_b <= '0;
            neg   <= 1'b0;
        end else if (load) begin
            mag_a <= abs_a;
            mag_b <= abs_b;
            // Result is negative only when exactly one operand is.
            neg   <= signed_mode & (a[WIDTH-1] ^ b[WIDTH-1]);
        end
    end

endmodule

//--- control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic in_valid,
    input  logic done,
    output logic load,
    output logic processing,
    output logic calc
);

    import mul_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    // State register.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Next state and outputs.
    always_comb begin
        // Defaults keep everything quiet and the state unchanged.
        next_state = state;
        load       = 1'b0;
        calc       = 1'b0;
        processing = 1'b0;

        case (state)
            IDLE: begin
                // Start is only looked at here, so a start while busy is lost.
                if (start) begin
                    next_state = LOAD;
                end
            end

            LOAD: begin
                // Mealy output, load follows in_valid directly.
                if (in_valid) begin
                    load       = 1'b1;
                    next_state = CALC;
                end else begin
                    // No operands, abandon the request.
                    next_state = IDLE;
                end
            end

            CALC: begin
                // Calc stays high in the last step too.
                // The datapath needs it to form done.
                calc       = 1'b1;
                processing = 1'b1;
                if (done) begin
                    next_state = IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

//--- shift_add_multiplier.sv
`timescale 1ns/10ps

module shift_add_multiplier #(
    parameter int WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  logic                 calc,
    input  logic [WIDTH-1:0]     mag_a,
    input  logic [WIDTH-1:0]     mag_b,
    output logic [2*WIDTH-1:0]   product,
    output logic                 done
);

    // Step counter is wide enough to reach WIDTH-1.
    localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(WIDTH - 1);

    logic [2*WIDTH-1:0] acc;
    logic [2*WIDTH-1:0] addend;
    logic [2*WIDTH-1:0] acc_next;
    logic [CNT_W-1:0]   cnt;

    // Partial product for this step.
    // mag_a is shifted to the weight of the current multiplier bit.
    always_comb begin
        if (calc && mag_b[cnt]) begin
            addend = {{WIDTH{1'b0}}, mag_a} << cnt;
        end else begin
            addend = '0;
        end
    end

    assign acc_next = acc + addend;

    // Output already includes this cycle's add.
    // The full product is therefore ready while done is high.
    assign product = acc_next;
    assign done    = calc && (cnt == LAST_STEP);

    // Accumulator and step counter.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
            cnt <= '0;
        end else if (load) begin
            acc <= '0;
            cnt <= '0;
        end else if (calc) begin
            acc <= acc_next;
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- result_stage.sv
`timescale 1ns/10ps

module result_stage #(
    parameter int WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 done,
    input  logic                 neg,
    input  logic [2*WIDTH-1:0]   product,
    output logic [2*WIDTH-1:0]   result,
    output logic                 result_valid
);

    logic [2*WIDTH-1:0] signed_product;

    // Put the sign back on the unsigned product.
    assign signed_product = neg ? (~product + 1'b1) : product;

    // Strobe for one cycle after done.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= done;
        end
    end

    // Result holds until the next operation finishes.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (done) begin
            result <= signed_product;
        end
    end

endmodule

//--- mul_top.sv
`timescale 1ns/10ps

module mul_top #(
    parameter int WIDTH = mul_types_pkg::DEFAULT_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    in_valid,
    input  mul_types_pkg::op_mode_t mode,
    input  logic [WIDTH-1:0]        a,
    input  logic [WIDTH-1:0]        b,
    output logic                    busy,
    output logic [2*WIDTH-1:0]      result,
    output logic                    result_valid
);

    // Controller strobes.
    logic load;
    logic calc;
    logic processing;

    // Conditioned operands and sign.
    logic [WIDTH-1:0]   mag_a;
    logic [WIDTH-1:0]   mag_b;
    logic               neg;

    // Datapath outputs.
    logic [2*WIDTH-1:0] product;
    logic               done;

    // Busy covers the whole calculation.
    assign busy = processing;

    // Input side.
    operand_conditioner #(
        .WIDTH (WIDTH)
    ) u_cond (
        .clk   (clk),
        .rst   (rst),
        .load  (load),
        .mode  (mode),
        .a     (a),
        .b     (b),
        .mag_a (mag_a),
        .mag_b (mag_b),
        .neg   (neg)
    );

    // Sequencing.
    control_unit u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .in_valid   (in_valid),
        .done       (done),
        .load       (load),
        .processing (processing),
        .calc       (calc)
    );

    // One shift-add step per calc cycle.
    shift_add_multiplier #(
        .WIDTH (WIDTH)
    ) u_mult (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .calc    (calc),
        .mag_a   (mag_a),
        .mag_b   (mag_b),
        .product (product),
        .done    (done)
    );

    // Output side.
    result_stage #(
        .WIDTH (WIDTH)
    ) u_res (
        .clk          (clk),
        .rst          (rst),
        .done         (done),
        .neg          (neg),
        .product      (product),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- tb_mul_top.sv
`timescale 1ns/10ps

module tb_mul_top;

    import mul_types_pkg::*;

    localparam int WIDTH         = DEFAULT_WIDTH;
    localparam int DW            = 2 * WIDTH;
    localparam int CLK_NS        = 100;
    localparam int DRIVE_NS      = 5;
    localparam int RESET_CYCLES  = 10;

    // Operation counts per test group.
    localparam int NUM_RANDOM    = 200;
    localparam int NUM_CORNER    = 32;
    localparam int NUM_ABORT     = 4;
    localparam int NUM_POKE      = 4;

    // Each abort is followed by a normal operation.
    localparam int NUM_OPS       = 2 * NUM_RANDOM + NUM_CORNER + 2 * NUM_ABORT + NUM_POKE;

    // Start, load, WIDTH calc cycles, strobe check, plus slack.
    localparam int OP_CYCLES     = WIDTH + 4;
    localparam int MARGIN_CYCLES = 50;
    localparam int LIMIT_CYCLES  = RESET_CYCLES + NUM_OPS * OP_CYCLES + MARGIN_CYCLES;

    logic             clk;
    logic             rst;
    logic             start;
    logic             in_valid;
    op_mode_t         mode;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic             busy;
    logic [DW-1:0]    result;
    logic             result_valid;

    integer           seed;

    // Value the DUT result register should hold between operations.
    logic [DW-1:0]    last_result;

    // Corner operands, filled in at the start of the run.
    logic [WIDTH-1:0] corners [4];

    mul_top #(
        .WIDTH (WIDTH)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .in_valid     (in_valid),
        .mode         (mode),
        .a            (a),
        .b            (b),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid)
    );

    // Free running clock.
    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_NS / 2) clk = ~clk;
        end
    end

    // Ends the run if the tests stall.
    initial begin
        #(LIMIT_CYCLES * CLK_NS);
        fail_run($sformatf("Timeout: the tests did not finish within %0d cycles",
                           LIMIT_CYCLES));
    end

    // Prints the reason, then the fail message, then stops.
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Stopping at the first error.");
    endtask

    // Single comparison point for every checked value.
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAIL %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
        end
    endtask

    // Advance to the drive point just after the next rising edge.
    // Registered outputs have settled there as well.
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_NS;
    endtask

    // Reference product.
    // Operands are widened by the mode rule and multiplied at full width.
    function automatic logic [DW-1:0] model_product(input op_mode_t m,
                                                    input logic [WIDTH-1:0] x,
                                                    input logic [WIDTH-1:0] y);
        logic signed [DW-1:0] sx;
        logic signed [DW-1:0] sy;
        logic        [DW-1:0] ux;
        logic        [DW-1:0] uy;
        sx = $signed(x);
        sy = $signed(y);
        ux = x;
        uy = y;
        if (m == MODE_SIGNED) begin
            return sx * sy;
        end else begin
            return ux * uy;
        end
    endfunction

    // One complete operation with latency, busy and strobe checks.
    // poke_cycle >= 0 raises start once during CALC at that cycle.
    task automatic run_op(input string name, input op_mode_t op_mode,
                          input logic [WIDTH-1:0] op_a, input logic [WIDTH-1:0] op_b,
                          input int poke_cycle);
        logic [DW-1:0] expected;
        int            lat;
        expected = model_product(op_mode, op_a, op_b);

        // Start is only seen in IDLE.
        start = 1'b1;
        next_cycle();

        // Operands on the bus while the controller sits in LOAD.
        start    = 1'b0;
        in_valid = 1'b1;
        mode     = op_mode;
        a        = op_a;
        b        = op_b;
        next_cycle();

        // Load edge is behind us.
        // Scrambled inputs would show up if the DUT sampled them again.
        in_valid = 1'b0;
        mode     = (op_mode == MODE_SIGNED) ? MODE_UNSIGNED : MODE_SIGNED;
        a        = $random(seed);
        b        = $random(seed);

        lat = 0;
        while (result_valid !== 1'b1 && lat <= WIDTH + 2) begin
            if (lat < WIDTH) begin
                check_value({name, " busy"}, 1'b1, busy);
            end
            // Old result must stay put until done.
            check_value({name, " result before done"}, last_result, result);
            start = (lat == poke_cycle);
            next_cycle();
            lat++;
        end
        start = 1'b0;

        if (result_valid !== 1'b1) begin
            fail_run({name, ": no result_valid pulse arrived after the load"});
        end
        check_value({name, " latency"}, WIDTH, lat);
        check_value({name, " busy at result"}, 1'b0, busy);
        check_value({name, " result"}, expected, result);
        last_result = expected;

        // Strobe is one cycle wide and the value holds afterwards.
        next_cycle();
        check_value({name, " result_valid width"}, 1'b0, result_valid);
        check_value({name, " result hold"}, expected, result);
        check_value({name, " busy after result"}, 1'b0, busy);
    endtask

    // Start followed by a LOAD cycle without in_valid.
    task automatic run_abort(input string name);
        int i;
        start = 1'b1;
        next_cycle();

        // Operands present but not qualified.
        start    = 1'b0;
        in_valid = 1'b0;
        mode     = MODE_SIGNED;
        a        = $random(seed);
        b        = $random(seed);
        for (i = 0; i < WIDTH + 2; i++) begin
            check_value({name, " result_valid"}, 1'b0, result_valid);
            check_value({name, " busy"}, 1'b0, busy);
            check_value({name, " result kept"}, last_result, result);
            next_cycle();
        end
    endtask

    initial begin : main_seq
        int               i;
        int               j;
        logic [WIDTH-1:0] op_a;
        logic [WIDTH-1:0] op_b;
        op_mode_t         op_mode;

        seed        = 32'h393c_1948;
        last_result = '0;

        // Zero, one, all ones, most negative.
        corners[0] = '0;
        corners[1] = {{(WIDTH-1){1'b0}}, 1'b1};
        corners[2] = '1;
        corners[3] = {1'b1, {(WIDTH-1){1'b0}}};

        rst      = 1'b1;
        start    = 1'b0;
        in_valid = 1'b0;
        mode     = MODE_UNSIGNED;
        a        = '0;
        b        = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_NS;
        rst = 1'b0;

        // Reset state.
        check_value("reset busy", 1'b0, busy);
        check_value("reset result_valid", 1'b0, result_valid);
        check_value("reset result", '0, result);
        next_cycle();

        // Unsigned random pairs.
        for (i = 0; i < NUM_RANDOM; i++) begin
            op_a = $random(seed);
            op_b = $random(seed);
            run_op($sformatf("unsigned #%0d", i), MODE_UNSIGNED, op_a, op_b, -1);
        end

        // Signed random pairs.
        for (i = 0; i < NUM_RANDOM; i++) begin
            op_a = $random(seed);
            op_b = $random(seed);
            run_op($sformatf("signed #%0d", i), MODE_SIGNED, op_a, op_b, -1);
        end

        // Every pairing of corner values in both modes.
        for (i = 0; i < 4; i++) begin
            for (j = 0; j < 4; j++) begin
                run_op($sformatf("corner unsigned %0h x %0h", corners[i], corners[j]),
                       MODE_UNSIGNED, corners[i], corners[j], -1);
                run_op($sformatf("corner signed %0h x %0h", corners[i], corners[j]),
                       MODE_SIGNED, corners[i], corners[j], -1);
            end
        end

        // Aborted loads with a normal product after each one.
        for (i = 0; i < NUM_ABORT; i++) begin
            run_abort($sformatf("abort #%0d", i));
            op_a = $random(seed);
            op_b = $random(seed);
            run_op($sformatf("after abort #%0d", i), MODE_SIGNED, op_a, op_b, -1);
        end

        // Start pulses in the middle of CALC.
        for (i = 0; i < NUM_POKE; i++) begin
            op_a    = $random(seed);
            op_b    = $random(seed);
            op_mode = (i % 2 == 0) ? MODE_UNSIGNED : MODE_SIGNED;
            j       = $unsigned($random(seed)) % WIDTH;
            run_op($sformatf("start during calc #%0d", i), op_mode, op_a, op_b, j);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- files.f
mul_types_pkg.sv
mul_ctrl_pkg.sv
operand_conditioner.sv
control_unit.sv
shift_add_multiplier.sv
result_stage.sv
mul_top.sv
tb_mul_top.sv

//--- Bender.yml
package:
  name: seq_mul

sources:
  # Packages first, then the blocks, then the top level.
  - mul_types_pkg.sv
  - mul_ctrl_pkg.sv
  - operand_conditioner.sv
  - control_unit.sv
  - shift_add_multiplier.sv
  - result_stage.sv
  - mul_top.sv

  # Testbench, only for simulation.
  - target: test
    files:
      - tb_mul_top.sv
